//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal -j 0
TOP       = revo_encoder_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard src/*.sv) $(wildcard sim/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
src/revo_timing_pkg.sv
src/revo_regs_pkg.sv
src/revo_config_regs.sv
src/revo_discriminator.sv
src/revo_clock_encoder.sv
src/cal_word_serializer.sv
src/revo_encoder_top.sv
sim/revo_encoder_assertions.sv
sim/revo_encoder_tb.sv

//--- sim/revo_encoder_assertions.sv
`default_nettype none

module revo_encoder_assertions (
	input wire logic clock254,
	input wire logic reset,
	input wire logic [revo_timing_pkg::frame_cycles-1:0] ring,
	input wire logic trigger,
	input wire logic frame_start,
	input wire logic psel,
	input wire logic penable,
	input wire logic pready
);

	timeunit 1ns;
	timeprecision 100ps;

	// exactly one token in the frame ring
	ring_one_hot: assert property (@(posedge clock254) disable iff (reset) $onehot(ring))
		else $error("frame ring is not one-hot, ring = %b", ring);

	// triggers only at a frame boundary
	trigger_on_frame: assert property (@(posedge clock254) disable iff (reset)
		trigger |-> frame_start)
		else $error("trigger pulsed outside frame_start");

	// zero wait states
	ready_in_access: assert property (@(posedge clock254) disable iff (reset)
		(psel && penable) |-> pready)
		else $error("pready low in an apb access phase");

endmodule

bind revo_discriminator revo_encoder_assertions disc_checks (
	.clock254    (clock254),
	.reset       (reset),
	.ring        (ring),
	.trigger     (trigger),
	.frame_start (frame_start),
	.psel        (1'b0),
	.penable     (1'b0),
	.pready      (1'b0)
);

bind revo_config_regs revo_encoder_assertions regs_checks (
	.clock254    (clock254),
	.reset       (reset),
	.ring        (revo_timing_pkg::ring_init),
	.trigger     (trigger),
	.frame_start (frame_start),
	.psel        (psel),
	.penable     (penable),
	.pready      (pready)
);

`default_nettype wire

//--- sim/revo_encoder_tb.sv
`default_nettype none

module revo_encoder_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int apb_timeout = 8;
	localparam int marker_timeout = 30;
	localparam int word_bits = revo_timing_pkg::word_width;

	logic clock254;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [revo_regs_pkg::paddr_width-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic raw_revo;
	logic clock127_out;
	logic trg_out;
	logic trg_marker;
	logic cal_data;
	logic cal_frame;

	int error_count;
	int test_count;
	int test_errors_start;
	logic [7:0] lfsr_state;
	logic [word_bits-1:0] exp_idle;
	logic [word_bits-1:0] exp_marker;

	// observation state updated once per falling edge
	bit prev_valid;
	logic prev_clock;
	int marker_run;
	int marker_rises;
	int held_low_count;
	bit marker_due;
	int bit_index;
	logic [word_bits-1:0] word_shift;
	logic [word_bits-1:0] word_expected;
	bit word_is_marker;
	int words_checked;
	int marker_words;

	always #10 clock254 = ~clock254;

	revo_encoder_top dut (
		.clock254     (clock254),
		.reset        (reset),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.raw_revo     (raw_revo),
		.clock127_out (clock127_out),
		.trg_out      (trg_out),
		.trg_marker   (trg_marker),
		.cal_data     (cal_data),
		.cal_frame    (cal_frame)
	);

	// ------------------------------------------------------------------------
	// random source and check helpers
	// ------------------------------------------------------------------------
	// galois lfsr with polynomial x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic next_random_bit();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) begin
			lfsr_state = lfsr_state ^ 8'hB8;
		end
		return lsb;
	endfunction

	function automatic logic [word_bits-1:0] random_word();
		logic [word_bits-1:0] w;
		w = '0;
		for (int i = 0; i < word_bits; i++) begin
			w = {w[word_bits-2:0], next_random_bit()};
		end
		return w;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) else begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
			error_count++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			error_count++;
		end
	endtask

	task automatic begin_test();
		test_errors_start = error_count;
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = error_count - test_errors_start;
		test_count++;
		if (errs == 0) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: %0d errors", name, errs);
		end
	endtask

	// ------------------------------------------------------------------------
	// per-cycle observation of the encoded clock, marker and cal stream
	// ------------------------------------------------------------------------
	task automatic observe_cycle();
		if (prev_valid) begin
			check_equal("clock127_out", clock127_out, !prev_clock);
		end
		check_equal("trg_out", trg_out, trg_marker ? 1'b0 : clock127_out);
		if (trg_marker) begin
			if (marker_run == 0) begin
				marker_rises++;
				marker_due = 1'b1;
			end
			marker_run++;
			if (clock127_out) begin
				held_low_count++;
			end
		end else if (marker_run != 0) begin
			check_equal("trg_marker width", marker_run, revo_timing_pkg::frame_cycles);
			marker_run = 0;
		end
		// first word framed after a marker rise carries the marker pattern
		if (cal_frame) begin
			word_shift = {{(word_bits-1){1'b0}}, cal_data};
			bit_index = 1;
			word_is_marker = marker_due;
			word_expected = marker_due ? exp_marker : exp_idle;
			marker_due = 1'b0;
		end else if (bit_index < word_bits) begin
			word_shift = {word_shift[word_bits-2:0], cal_data};
			bit_index++;
		end
		if (bit_index == word_bits) begin
			check_equal("cal word", word_shift, word_expected);
			words_checked++;
			if (word_is_marker) begin
				marker_words++;
			end
			bit_index = word_bits + 1;
		end
		prev_clock = clock127_out;
		prev_valid = 1'b1;
	endtask

	task automatic next_cycle();
		@(negedge clock254);
		observe_cycle();
	endtask

	task automatic drive_cycles(input logic value, input int n);
		repeat (n) begin
			next_cycle();
			raw_revo = value;
		end
	endtask

	task automatic pulse(input int len);
		drive_cycles(1'b1, len);
		next_cycle();
		raw_revo = 1'b0;
	endtask

	task automatic wait_marker_rise(input int rises_before, input int limit);
		int n;
		for (n = 0; n < limit && marker_rises == rises_before; n++) begin
			next_cycle();
		end
		check_true(marker_rises != rises_before, "trg_marker did not rise in time");
	endtask

	// ------------------------------------------------------------------------
	// apb master
	// ------------------------------------------------------------------------
	task automatic apb_transfer(input logic write, input logic [3:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int n;
		bit done;
		done = 1'b0;
		rdata = '0;
		err = 1'b0;
		next_cycle();
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		next_cycle();
		penable = 1'b1;
		for (n = 0; n < apb_timeout && !done; n++) begin
			#2;
			if (pready) begin
				done = 1'b1;
				rdata = prdata;
				err = pslverr;
			end else begin
				next_cycle();
			end
		end
		check_true(done, $sformatf("apb transfer to address 0x%0h never completed", addr));
		next_cycle();
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] unused_data;
		logic err;
		apb_transfer(1'b1, addr, data, unused_data, err);
		check_equal("pslverr", err, 0);
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
		output logic err);
		apb_transfer(1'b0, addr, 32'h0, data, err);
	endtask

	task automatic read_expect(input string name, input logic [3:0] addr,
		input logic [31:0] expected);
		logic [31:0] data;
		logic err;
		apb_read(addr, data, err);
		check_equal(name, data, expected);
		check_equal("pslverr", err, 0);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (10) @(negedge clock254);
		check_equal("clock127_out", clock127_out, 0);
		check_equal("trg_out", trg_out, 0);
		check_equal("trg_marker", trg_marker, 0);
		check_equal("cal_frame", cal_frame, 0);
		check_equal("cal_data", cal_data, 0);
		reset = 1'b0;
		prev_valid = 1'b0;
		marker_run = 0;
		marker_due = 1'b0;
		bit_index = word_bits + 1;
		exp_idle = 8'hF2;
		exp_marker = 8'hF4;
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic test_register_map();
		logic [word_bits-1:0] w_idle;
		logic [word_bits-1:0] w_marker;
		logic [31:0] data;
		logic err;
		begin_test();
		read_expect("ctrl", revo_regs_pkg::addr_ctrl, 32'h0);
		read_expect("idle_word", revo_regs_pkg::addr_idle_word, 32'hF2);
		read_expect("marker_word", revo_regs_pkg::addr_marker_word, 32'hF4);
		read_expect("trg_count", revo_regs_pkg::addr_trg_count, 32'h0);
		w_idle = random_word();
		w_marker = random_word();
		apb_write(revo_regs_pkg::addr_idle_word, {24'h0, w_idle});
		exp_idle = w_idle;
		apb_write(revo_regs_pkg::addr_marker_word, {24'h0, w_marker});
		exp_marker = w_marker;
		read_expect("idle_word", revo_regs_pkg::addr_idle_word, {24'h0, w_idle});
		read_expect("marker_word", revo_regs_pkg::addr_marker_word, {24'h0, w_marker});
		// unmapped address inside the 4-bit space
		apb_read(4'h2, data, err);
		check_equal("pslverr", err, 1);
		end_test("register map");
	endtask

	task automatic test_single_edge();
		int rises0;
		begin_test();
		apb_write(revo_regs_pkg::addr_ctrl, 32'h1);
		drive_cycles(1'b0, 20);
		rises0 = marker_rises;
		pulse(3);
		wait_marker_rise(rises0, marker_timeout - 4);
		drive_cycles(1'b0, 30);
		check_equal("trigger count", marker_rises - rises0, 1);
		read_expect("trg_count", revo_regs_pkg::addr_trg_count, 32'h1);
		// a long pulse still has one leading edge
		rises0 = marker_rises;
		drive_cycles(1'b0, 20);
		pulse(40);
		drive_cycles(1'b0, 40);
		check_equal("trigger count", marker_rises - rises0, 1);
		read_expect("trg_count", revo_regs_pkg::addr_trg_count, 32'h2);
		end_test("single edge");
	endtask

	task automatic test_enable_gating();
		int rises0;
		begin_test();
		apb_write(revo_regs_pkg::addr_ctrl, 32'h0);
		rises0 = marker_rises;
		drive_cycles(1'b0, 20);
		pulse(3);
		drive_cycles(1'b0, 30);
		check_equal("trigger count", marker_rises - rises0, 0);
		// still the two triggers of the single edge test
		read_expect("trg_count", revo_regs_pkg::addr_trg_count, 32'h2);
		apb_write(revo_regs_pkg::addr_trg_count, 32'h1);
		read_expect("trg_count", revo_regs_pkg::addr_trg_count, 32'h0);
		end_test("enable gating");
	endtask

	task automatic test_isolation();
		int rises0;
		begin_test();
		apb_write(revo_regs_pkg::addr_ctrl, 32'h1);
		apb_write(revo_regs_pkg::addr_trg_count, 32'h0);
		rises0 = marker_rises;
		drive_cycles(1'b0, 20);
		pulse(3);
		drive_cycles(1'b0, 29);
		pulse(3);
		drive_cycles(1'b0, 30);
		check_equal("trigger count", marker_rises - rises0, 2);
		read_expect("trg_count", revo_regs_pkg::addr_trg_count, 32'h2);
		// pulses 3 quiet cycles apart look like one revolution
		apb_write(revo_regs_pkg::addr_trg_count, 32'h0);
		rises0 = marker_rises;
		drive_cycles(1'b0, 20);
		pulse(1);
		drive_cycles(1'b0, 2);
		pulse(1);
		drive_cycles(1'b0, 30);
		check_equal("trigger count", marker_rises - rises0, 1);
		read_expect("trg_count", revo_regs_pkg::addr_trg_count, 32'h1);
		end_test("isolation");
	endtask

	task automatic test_clock_encoding();
		int rises0;
		int held0;
		begin_test();
		rises0 = marker_rises;
		held0 = held_low_count;
		drive_cycles(1'b0, 20);
		pulse(3);
		wait_marker_rise(rises0, marker_timeout - 4);
		drive_cycles(1'b0, 20);
		// the clock is high in two of the four marker cycles
		check_equal("held-low cycles", held_low_count - held0, 2);
		end_test("clock encoding");
	endtask

	task automatic test_cal_stream();
		int rises0;
		int words0;
		int marker0;
		logic [word_bits-1:0] w;
		begin_test();
		w = random_word();
		apb_write(revo_regs_pkg::addr_idle_word, {24'h0, w});
		exp_idle = w;
		apb_write(revo_regs_pkg::addr_marker_word, {24'h0, ~w});
		exp_marker = ~w;
		words0 = words_checked;
		marker0 = marker_words;
		drive_cycles(1'b0, 40);
		check_equal("idle words", words_checked - words0, 5);
		check_equal("marker words", marker_words - marker0, 0);
		rises0 = marker_rises;
		pulse(3);
		wait_marker_rise(rises0, marker_timeout - 4);
		drive_cycles(1'b0, 40);
		check_equal("marker words", marker_words - marker0, 1);
		end_test("cal stream");
	endtask

	initial begin
		clock254 = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		raw_revo = 1'b0;
		lfsr_state = 8'd82;
		error_count = 0;
		test_count = 0;
		apply_reset();
		test_register_map();
		test_single_edge();
		test_enable_gating();
		test_isolation();
		test_clock_encoding();
		test_cal_stream();
		$display("tests run: %0d, errors: %0d", test_count, error_count);
		if (error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src/cal_word_serializer.sv
`default_nettype none

module cal_word_serializer (
	input  wire logic clock254,
	input  wire logic reset,
	input  wire logic trigger,
	input  wire logic [revo_timing_pkg::word_width-1:0] idle_word,
	input  wire logic [revo_timing_pkg::word_width-1:0] marker_word,
	output logic cal_data,
	output logic cal_frame
);

	logic [revo_timing_pkg::bit_count_width-1:0] bit_count;
	logic load;
	logic pending;
	logic [revo_timing_pkg::word_width-1:0] shift_reg;

	assign load = (bit_count == '0);

	// word period
	always_ff @(posedge clock254) begin
		if (reset) begin
			bit_count <= '0;
		end else if (bit_count == revo_timing_pkg::bit_count_last) begin
			bit_count <= '0;
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// word select and shift out
	// ------------------------------------------------------------------------
	always_ff @(posedge clock254) begin
		if (reset) begin
			pending <= 1'b0;
			shift_reg <= '0;
			cal_frame <= 1'b0;
		end else begin
			cal_frame <= load;
			if (load) begin
				// a trigger in the load cycle counts for this word
				shift_reg <= (pending || trigger) ? marker_word : idle_word;
				pending <= 1'b0;
			end else begin
				shift_reg <= {shift_reg[revo_timing_pkg::word_width-2:0], 1'b0};
				if (trigger) begin
					pending <= 1'b1;
				end
			end
		end
	end

	// msb first
	assign cal_data = shift_reg[revo_timing_pkg::word_width-1];

endmodule

`default_nettype wire

//--- src/revo_clock_encoder.sv
`default_nettype none

module revo_clock_encoder (
	input  wire logic clock254,
	input  wire logic reset,
	input  wire logic trigger,
	input  wire logic frame_start,
	output logic clock127_out,
	output logic trg_out,
	output logic trg_marker
);

	logic [revo_timing_pkg::marker_width-1:0] marker_count;

	// ------------------------------------------------------------------------
	// half-rate reference and marker frame
	// ------------------------------------------------------------------------
	always_ff @(posedge clock254) begin
		if (reset) begin
			clock127_out <= 1'b0;
		end else begin
			clock127_out <= ~clock127_out;
		end
	end

	// counts down one full frame after the trigger cycle
	always_ff @(posedge clock254) begin
		if (reset) begin
			marker_count <= '0;
		end else if (trigger && frame_start) begin
			marker_count <= revo_timing_pkg::marker_init;
		end else if (marker_count != '0) begin
			marker_count <= marker_count - 1'b1;
		end
	end

	assign trg_marker = (marker_count != '0);

	// encoded copy stops toggling for the marker frame
	assign trg_out = clock127_out & ~trg_marker;

endmodule

`default_nettype wire

//--- src/revo_config_regs.sv
`default_nettype none

module revo_config_regs (
	input  wire logic clock254,
	input  wire logic reset,
	input  wire logic psel,
	input  wire logic penable,
	input  wire logic pwrite,
	input  wire logic [revo_regs_pkg::paddr_width-1:0] paddr,
	input  wire logic [revo_regs_pkg::apb_data_width-1:0] pwdata,
	input  wire logic trigger,
	input  wire logic frame_start,
	output logic [revo_regs_pkg::apb_data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic enable,
	output logic [revo_timing_pkg::word_width-1:0] idle_word,
	output logic [revo_timing_pkg::word_width-1:0] marker_word
);

	logic write_access;
	logic addr_hit;
	logic count_up;
	logic [revo_regs_pkg::count_width-1:0] trg_count;

	// zero wait states, every access phase completes
	assign pready = psel & penable;
	assign write_access = psel & penable & pwrite;
	// triggers only ever land on a frame boundary
	assign count_up = trigger & frame_start;

	// ------------------------------------------------------------------------
	// read decode
	// ------------------------------------------------------------------------
	always_comb begin
		prdata = '0;
		addr_hit = 1'b1;
		case (paddr)
			revo_regs_pkg::addr_ctrl: prdata[0] = enable;
			revo_regs_pkg::addr_idle_word: prdata[revo_timing_pkg::word_width-1:0] = idle_word;
			revo_regs_pkg::addr_marker_word: begin
				prdata[revo_timing_pkg::word_width-1:0] = marker_word;
			end
			revo_regs_pkg::addr_trg_count: prdata[revo_regs_pkg::count_width-1:0] = trg_count;
			default: addr_hit = 1'b0;
		endcase
	end

	// error only in the access phase of an unmapped address
	assign pslverr = psel & penable & ~addr_hit;

	// ------------------------------------------------------------------------
	// control and calibration words
	// ------------------------------------------------------------------------
	always_ff @(posedge clock254) begin
		if (reset) begin
			enable <= 1'b0;
			idle_word <= revo_regs_pkg::idle_word_reset;
			marker_word <= revo_regs_pkg::marker_word_reset;
		end else if (write_access) begin
			case (paddr)
				revo_regs_pkg::addr_ctrl: enable <= pwdata[0];
				revo_regs_pkg::addr_idle_word: begin
					idle_word <= pwdata[revo_timing_pkg::word_width-1:0];
				end
				revo_regs_pkg::addr_marker_word: begin
					marker_word <= pwdata[revo_timing_pkg::word_width-1:0];
				end
				default: ;
			endcase
		end
	end

	// trigger counter, a write clears it ahead of any increment
	always_ff @(posedge clock254) begin
		if (reset) begin
			trg_count <= '0;
		end else if (write_access && paddr == revo_regs_pkg::addr_trg_count) begin
			trg_count <= '0;
		end else if (count_up && trg_count != '1) begin
			trg_count <= trg_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/revo_discriminator.sv
`default_nettype none

module revo_discriminator (
	input  wire logic clock254,
	input  wire logic reset,
	input  wire logic raw_revo,
	input  wire logic enable,
	output logic trigger,
	output logic frame_start
);

	logic [1:0] sync_ff;
	logic [revo_timing_pkg::stream_width-1:0] stream;
	logic [revo_timing_pkg::frame_cycles-1:0] ring;
	logic [revo_timing_pkg::max_duration-1:0] recent;
	logic [revo_timing_pkg::quiet_width-1:0] quiet;
	logic recent_any;
	logic quiet_any;
	logic decision;
	logic [revo_timing_pkg::holdoff_width-1:0] holdoff_count;

	assign frame_start = ring[0];

	// ------------------------------------------------------------------------
	// synchronizer, sample stream and frame ring
	// ------------------------------------------------------------------------
	always_ff @(posedge clock254) begin
		if (reset) begin
			sync_ff <= '0;
			stream <= '0;
			ring <= revo_timing_pkg::ring_init;
		end else begin
			sync_ff <= {sync_ff[0], raw_revo};
			// newest sample enters at bit 0
			stream <= {stream[revo_timing_pkg::stream_width-2:0], sync_ff[1]};
			ring <= {ring[revo_timing_pkg::frame_cycles-2:0],
				ring[revo_timing_pkg::frame_cycles-1]};
		end
	end

	// ------------------------------------------------------------------------
	// decision, one phase per ring position
	// ------------------------------------------------------------------------
	always_ff @(posedge clock254) begin
		if (reset) begin
			recent <= '0;
			quiet <= '0;
			recent_any <= 1'b0;
			quiet_any <= 1'b0;
			decision <= 1'b0;
			trigger <= 1'b0;
		end else begin
			if (ring[0]) begin
				recent <= stream[revo_timing_pkg::max_duration-1:0];
				quiet <= stream[revo_timing_pkg::stream_width-1:revo_timing_pkg::max_duration];
			end
			if (ring[1]) begin
				recent_any <= |recent;
				quiet_any <= |quiet;
			end
			// edge seen recently with silence before it
			if (ring[2]) begin
				decision <= enable & recent_any & ~quiet_any & (holdoff_count == '0);
			end
			// lands on the next frame_start
			trigger <= ring[revo_timing_pkg::frame_cycles-1] & decision;
		end
	end

	// suppress the frames right after a trigger
	always_ff @(posedge clock254) begin
		if (reset) begin
			holdoff_count <= '0;
		end else if (trigger) begin
			holdoff_count <= revo_timing_pkg::holdoff_init;
		end else if (frame_start && holdoff_count != '0) begin
			holdoff_count <= holdoff_count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/revo_encoder_top.sv
`default_nettype none

module revo_encoder_top (
	input  wire logic clock254,
	input  wire logic reset,
	input  wire logic psel,
	input  wire logic penable,
	input  wire logic pwrite,
	input  wire logic [revo_regs_pkg::paddr_width-1:0] paddr,
	input  wire logic [revo_regs_pkg::apb_data_width-1:0] pwdata,
	output logic [revo_regs_pkg::apb_data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input  wire logic raw_revo,
	output logic clock127_out,
	output logic trg_out,
	output logic trg_marker,
	output logic cal_data,
	output logic cal_frame
);

	logic enable;
	logic [revo_timing_pkg::word_width-1:0] idle_word;
	logic [revo_timing_pkg::word_width-1:0] marker_word;
	logic trigger;
	logic frame_start;

	// ------------------------------------------------------------------------
	// register block
	// ------------------------------------------------------------------------
	revo_config_regs u_regs (
		.clock254    (clock254),
		.reset       (reset),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.trigger     (trigger),
		.frame_start (frame_start),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.enable      (enable),
		.idle_word   (idle_word),
		.marker_word (marker_word)
	);

	// ------------------------------------------------------------------------
	// revolution path
	// ------------------------------------------------------------------------
	revo_discriminator u_disc (
		.clock254    (clock254),
		.reset       (reset),
		.raw_revo    (raw_revo),
		.enable      (enable),
		.trigger     (trigger),
		.frame_start (frame_start)
	);

	revo_clock_encoder u_enc (
		.clock254     (clock254),
		.reset        (reset),
		.trigger      (trigger),
		.frame_start  (frame_start),
		.clock127_out (clock127_out),
		.trg_out      (trg_out),
		.trg_marker   (trg_marker)
	);

	// calibration stream
	cal_word_serializer u_ser (
		.clock254    (clock254),
		.reset       (reset),
		.trigger     (trigger),
		.idle_word   (idle_word),
		.marker_word (marker_word),
		.cal_data    (cal_data),
		.cal_frame   (cal_frame)
	);

endmodule

`default_nettype wire

//--- src/revo_regs_pkg.sv
`default_nettype none

package revo_regs_pkg;

	// ------------------------------------------------------------------------
	// apb bus geometry
	// ------------------------------------------------------------------------
	localparam int paddr_width = 4;
	localparam int apb_data_width = 32;

	// register map
	localparam logic [paddr_width-1:0] addr_ctrl = 4'h0;
	localparam logic [paddr_width-1:0] addr_idle_word = 4'h4;
	localparam logic [paddr_width-1:0] addr_marker_word = 4'h8;
	localparam logic [paddr_width-1:0] addr_trg_count = 4'hC;

	// ------------------------------------------------------------------------
	// reset values and counter
	// ------------------------------------------------------------------------
	// idle pattern, sent when no trigger happened
	localparam logic [revo_timing_pkg::word_width-1:0] idle_word_reset = 8'hF2;
	// pattern sent once after each trigger
	localparam logic [revo_timing_pkg::word_width-1:0] marker_word_reset = 8'hF4;

	// saturating trigger counter
	localparam int count_width = 16;

endpackage

`default_nettype wire

//--- src/revo_timing_pkg.sv
`default_nettype none

package revo_timing_pkg;

	// ------------------------------------------------------------------------
	// sample stream
	// ------------------------------------------------------------------------
	localparam int stream_width = 12;
	// newest samples, the rest is the quiet window
	localparam int max_duration = 6;
	localparam int quiet_width = stream_width - max_duration;

	// ------------------------------------------------------------------------
	// frame ring and holdoff
	// ------------------------------------------------------------------------
	localparam int frame_cycles = 4;
	localparam logic [frame_cycles-1:0] ring_init = frame_cycles'(1);
	localparam int holdoff_frames = 2;
	localparam int holdoff_width = $clog2(holdoff_frames + 1);
	localparam logic [holdoff_width-1:0] holdoff_init = holdoff_width'(holdoff_frames);
	// marker lasts one whole frame
	localparam int marker_width = $clog2(frame_cycles + 1);
	localparam logic [marker_width-1:0] marker_init = marker_width'(frame_cycles);

	// ------------------------------------------------------------------------
	// calibration serializer
	// ------------------------------------------------------------------------
	localparam int word_width = 8;
	localparam int bit_count_width = $clog2(word_width);
	localparam logic [bit_count_width-1:0] bit_count_last = bit_count_width'(word_width - 1);

endpackage

`default_nettype wire
